//--- hw/backup_sector_seq.sv
// Requests made while a transfer runs are dropped; sd_ack must rise and fall once per sector
`timescale 1ns/1ps
`default_nettype none

module backup_sector_seq (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      cart_download,
	input  wire                      img_mounted,
	input  wire                      img_readonly,
	input  wire                      img_size_nz,
	input  wire cart_pkg::mem_mask_t ram_mask,
	input  wire                      bk_load_req,
	input  wire                      bk_save_req,
	input  wire                      autosave_en,
	input  wire                      osd_status,
	input  wire                      bsram_write,
	input  wire                      sd_ack,
	output host_pkg::sector_t        sd_lba,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     bk_busy,
	output logic                     bk_loading,
	output logic                     bk_pending
);

	typedef enum logic [1:0] {
		idle,
		request,
		wait_ack_fall
	} seq_state_t;

	seq_state_t        state;
	logic              bk_ena;
	logic              download_d;
	logic              load_d;
	logic              save_d;
	logic              save_lvl;
	logic              load_rise;
	logic              save_rise;
	logic              download_end;
	logic              start;
	logic              start_load;
	logic              sector_done;
	logic              last_done;
	host_pkg::sector_t last_sector;

	// ==========================================================================
	// Request detection
	// ==========================================================================

	// Autosave once the menu opens with unsaved writes
	assign save_lvl = bk_save_req || (bk_pending && osd_status && autosave_en);
	assign load_rise = bk_load_req && !load_d;
	assign save_rise = save_lvl && !save_d;
	assign download_end = download_d && !cart_download;

	// Load wins when both show up together
	assign start_load = bk_ena && (load_rise || (download_end && img_size_nz));
	assign start = (state == idle) && (start_load || (bk_ena && save_rise));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			load_d <= 1'b0;
			save_d <= 1'b0;
			bk_ena <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			download_d <= cart_download;
			load_d <= bk_load_req;
			save_d <= save_lvl;
			// Save file gets mounted while the ROM is still loading
			if (cart_download && !download_d)
				bk_ena <= 1'b0;
			else if (cart_download && img_mounted && !img_readonly)
				bk_ena <= (ram_mask != '0);
			if (start)
				bk_pending <= 1'b0;
			else if (bsram_write && !osd_status)
				bk_pending <= 1'b1;
		end
	end

	// ==========================================================================
	// Sector stepping
	// ==========================================================================
	assign last_sector = host_pkg::sector_t'(ram_mask >> host_pkg::sector_shift);
	assign sector_done = (state == wait_ack_fall) && !sd_ack;
	assign last_done = sector_done && (sd_lba >= last_sector);
	assign bk_busy = (state != idle);

	always_ff @(posedge clk_sys) begin
		if (start)
			sd_lba <= '0;
		else if (sector_done && !last_done)
			sd_lba <= sd_lba + 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= idle;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= request;
						sd_rd <= start_load;
						sd_wr <= !start_load;
						bk_loading <= start_load;
					end
				end
				request: begin
					// Host took the sector
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= wait_ack_fall;
					end
				end
				wait_ack_fall: begin
					if (last_done) begin
						state <= idle;
						bk_loading <= 1'b0;
					end else if (sector_done) begin
						sd_rd <= bk_loading;
						sd_wr <= !bk_loading;
						state <= request;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Host side sees one direction per transfer
	assert property (@(posedge clk_sys) disable iff (reset) !(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr both high");

endmodule

`default_nettype wire

//--- hw/cart_pkg.sv
// Cartridge header encodings; a size code of 14 or more gives a mask of all ones in 24 bits
`default_nettype none

package cart_pkg;

	// ==========================================================================
	// Menu settings
	// ==========================================================================

	// ROM header option, same order as the menu entries
	typedef enum logic [2:0] {
		hdr_auto,
		hdr_no_header,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} header_mode_t;

	// Power-on contents of work RAM
	typedef enum logic [1:0] {
		wram_snes2_9966,
		wram_snes1_00ff,
		wram_fill_55,
		wram_fill_ff
	} wram_init_t;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_t;

	// ==========================================================================
	// Header fields and derived masks
	// ==========================================================================
	typedef logic [7:0]  mapper_t;
	typedef logic [23:0] mem_mask_t;
	typedef logic [3:0]  size_code_t;

	// Copier header in front of the image
	localparam int unsigned copier_offset = 512;

	// Info block word holding the ROM size byte in its upper half
	localparam logic [23:0] info_lorom   = 24'h007FD6;
	localparam logic [23:0] info_hirom   = 24'h00FFD6;
	localparam logic [23:0] info_exhirom = 24'h40FFD6;
	localparam int unsigned ram_size_step = 2;

	// 4 MB when nothing better is known
	localparam size_code_t default_rom_size = 4'hC;
	localparam int unsigned mask_base = 1024;

endpackage

`default_nettype wire

//--- hw/cheat_code_loader.sv
// Records are 16 bytes long; only even offsets carry data and offset 14 closes a record
`timescale 1ns/1ps
`default_nettype none

module cheat_code_loader (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        code_download,
	input  wire                        ioctl_wr,
	input  wire host_pkg::ioctl_addr_t ioctl_addr,
	input  wire host_pkg::ioctl_word_t ioctl_dout,
	output host_pkg::cheat_code_t      gg_code,
	output logic                       gg_valid
);

	logic code_wr;

	assign code_wr = code_download && ioctl_wr;

	// Slot per word, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code[111:96]  <= ioctl_dout;
				4'd2:  gg_code[127:112] <= ioctl_dout;
				4'd4:  gg_code[79:64]   <= ioctl_dout;
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout;
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout;
				4'd14: gg_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of the record, hand it to the core
	always_ff @(posedge clk_sys) begin
		if (reset)
			gg_valid <= 1'b0;
		else
			gg_valid <= code_wr && ioctl_addr[3:0] == 4'd14;
	end

	// The host spaces its writes, so each record strobes once
	assert property (@(posedge clk_sys) disable iff (reset) gg_valid |=> !gg_valid)
		else $error("gg_valid held for two cycles");

endmodule

`default_nettype wire

//--- hw/host_pkg.sv
// Host side widths; ioctl addresses are byte addresses that step by two per 16-bit word
`default_nettype none

package host_pkg;

	// ==========================================================================
	// Download stream
	// ==========================================================================
	typedef logic [24:0] ioctl_addr_t;
	typedef logic [15:0] ioctl_word_t;

	// Index of the cheat file download, everything else is a cartridge
	localparam logic [7:0] code_index = 8'hFF;

	// Cheat record, top to bottom
	//   127:96 flags
	//   95:64  address
	//   63:32  compare
	//   31:0   replace
	typedef logic [127:0] cheat_code_t;

	// ==========================================================================
	// Backup RAM sectors and RAM fill
	// ==========================================================================
	typedef logic [31:0] sector_t;

	// 512 bytes per sector
	localparam int unsigned sector_shift = 9;

	// 128 KB of work RAM
	localparam int unsigned fill_addr_bits = 17;
	typedef logic [fill_addr_bits-1:0] fill_addr_t;

endpackage

`default_nettype wire

//--- hw/rom_header_detect.sv
// Header words count only while cart_download is high; forced modes expect the copier header
`timescale 1ns/1ps
`default_nettype none

module rom_header_detect (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire                        cart_download,
	input  wire                        ioctl_wr,
	input  wire host_pkg::ioctl_addr_t ioctl_addr,
	input  wire host_pkg::ioctl_word_t ioctl_dout,
	input  wire cart_pkg::header_mode_t header_mode,
	input  wire cart_pkg::region_sel_t region_sel,
	output cart_pkg::mapper_t          rom_type,
	output cart_pkg::mem_mask_t        rom_mask,
	output cart_pkg::mem_mask_t        ram_mask,
	output logic                       pal
);

	cart_pkg::size_code_t  rom_size;
	cart_pkg::size_code_t  ram_size;
	cart_pkg::size_code_t  rom_size_nx;
	cart_pkg::size_code_t  ram_size_nx;
	cart_pkg::mapper_t     type_nx;
	logic [23:0]           info_base;
	logic                  has_info;
	host_pkg::ioctl_addr_t rom_size_addr;
	host_pkg::ioctl_addr_t ram_size_addr;
	logic                  header_wr;
	logic                  rom_region;

	function automatic cart_pkg::mem_mask_t size_to_mask(input cart_pkg::size_code_t code);
		return (cart_pkg::mem_mask_t'(cart_pkg::mask_base) << code) - 1'b1;
	endfunction

	assign header_wr = cart_download && ioctl_wr;

	// Info block location for the forced layouts
	always_comb begin
		has_info = 1'b1;
		case (header_mode)
			cart_pkg::hdr_lorom:   info_base = cart_pkg::info_lorom;
			cart_pkg::hdr_hirom:   info_base = cart_pkg::info_hirom;
			cart_pkg::hdr_exhirom: info_base = cart_pkg::info_exhirom;
			default: begin
				info_base = '0;
				has_info = 1'b0;
			end
		endcase
	end

	assign rom_size_addr = host_pkg::ioctl_addr_t'(info_base + cart_pkg::copier_offset);
	assign ram_size_addr = host_pkg::ioctl_addr_t'(rom_size_addr + cart_pkg::ram_size_step);

	// Next header values, so the masks follow on the same edge
	always_comb begin
		rom_size_nx = rom_size;
		ram_size_nx = ram_size;
		type_nx = rom_type;
		if (header_wr && ioctl_addr == '0) begin
			rom_size_nx = cart_pkg::default_rom_size;
			ram_size_nx = '0;
			// Copier header word, low byte holds both size codes
			if (header_mode == cart_pkg::hdr_auto && ioctl_dout[7:0] != 8'h00) begin
				rom_size_nx = ioctl_dout[3:0];
				ram_size_nx = ioctl_dout[7:4];
			end
			case (header_mode)
				cart_pkg::hdr_no_header, cart_pkg::hdr_lorom: type_nx = 8'd0;
				cart_pkg::hdr_hirom:   type_nx = 8'd1;
				cart_pkg::hdr_exhirom: type_nx = 8'd2;
				default:               type_nx = ioctl_dout[15:8];
			endcase
		end
		if (header_wr && has_info) begin
			if (ioctl_addr == rom_size_addr)
				rom_size_nx = ioctl_dout[11:8];
			if (ioctl_addr == ram_size_addr)
				ram_size_nx = ioctl_dout[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size <= cart_pkg::default_rom_size;
			ram_size <= '0;
			rom_type <= '0;
			rom_mask <= size_to_mask(cart_pkg::default_rom_size);
			ram_mask <= '0;
			rom_region <= 1'b0;
			pal <= 1'b0;
		end else begin
			rom_size <= rom_size_nx;
			ram_size <= ram_size_nx;
			rom_type <= type_nx;
			rom_mask <= size_to_mask(rom_size_nx);
			ram_mask <= (ram_size_nx != '0) ? size_to_mask(ram_size_nx) : '0;
			if (header_wr && ioctl_addr == host_pkg::ioctl_addr_t'(2))
				rom_region <= ioctl_dout[8];
			// Region only switches outside of a load
			if (!cart_download)
				pal <= (region_sel == cart_pkg::region_auto) ? rom_region :
					(region_sel == cart_pkg::region_pal);
		end
	end

	// Core address decode relies on a usable ROM mask at all times
	assert property (@(posedge clk_sys) disable iff (reset) rom_mask != '0)
		else $error("rom_mask is zero");

endmodule

`default_nettype wire

//--- hw/snes_cart_ctrl.sv
// Only the load control is here; RAM arrays, SDRAM and the sector data path stay outside
`timescale 1ns/1ps
`default_nettype none

module snes_cart_ctrl (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         ioctl_download,
	input  wire [7:0]                   ioctl_index,
	input  wire host_pkg::ioctl_addr_t  ioctl_addr,
	input  wire host_pkg::ioctl_word_t  ioctl_dout,
	input  wire                         ioctl_wr,
	input  wire cart_pkg::header_mode_t header_mode,
	input  wire cart_pkg::region_sel_t  region_sel,
	input  wire cart_pkg::wram_init_t   wram_init,
	input  wire                         img_mounted,
	input  wire                         img_readonly,
	input  wire                         img_size_nz,
	input  wire                         sd_ack,
	input  wire                         bk_load_req,
	input  wire                         bk_save_req,
	input  wire                         autosave_en,
	input  wire                         osd_status,
	input  wire                         bsram_write,
	output wire cart_pkg::mapper_t      rom_type,
	output wire cart_pkg::mem_mask_t    rom_mask,
	output wire cart_pkg::mem_mask_t    ram_mask,
	output wire                         pal,
	output wire host_pkg::cheat_code_t  gg_code,
	output wire                         gg_valid,
	output wire                         clearing,
	output wire host_pkg::fill_addr_t   fill_addr,
	output wire [7:0]                   fill_data,
	output wire                         fill_wren,
	output wire host_pkg::sector_t      sd_lba,
	output wire                         sd_rd,
	output wire                         sd_wr,
	output wire                         bk_busy,
	output wire                         bk_loading,
	output wire                         bk_pending,
	output wire                         core_hold
);

	logic code_download;
	logic cart_download;

	// Cheat files come on their own index
	assign code_download = ioctl_download && ioctl_index == host_pkg::code_index;
	assign cart_download = ioctl_download && ioctl_index != host_pkg::code_index;

	// Core stays in reset through load, clear and backup restore
	assign core_hold = cart_download || clearing || bk_loading;

	rom_header_detect header0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_download(cart_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.header_mode(header_mode),
		.region_sel(region_sel),
		.rom_type(rom_type),
		.rom_mask(rom_mask),
		.ram_mask(ram_mask),
		.pal(pal)
	);

	cheat_code_loader cheat0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.code_download(code_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.gg_code(gg_code),
		.gg_valid(gg_valid)
	);

	wram_clear_fill fill0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_download(cart_download),
		.wram_init(wram_init),
		.clearing(clearing),
		.fill_addr(fill_addr),
		.fill_data(fill_data),
		.fill_wren(fill_wren)
	);

	backup_sector_seq backup0 (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_download(cart_download),
		.img_mounted(img_mounted),
		.img_readonly(img_readonly),
		.img_size_nz(img_size_nz),
		.ram_mask(ram_mask),
		.bk_load_req(bk_load_req),
		.bk_save_req(bk_save_req),
		.autosave_en(autosave_en),
		.osd_status(osd_status),
		.bsram_write(bsram_write),
		.sd_ack(sd_ack),
		.sd_lba(sd_lba),
		.sd_rd(sd_rd),
		.sd_wr(sd_wr),
		.bk_busy(bk_busy),
		.bk_loading(bk_loading),
		.bk_pending(bk_pending)
	);

endmodule

`default_nettype wire

//--- hw/wram_clear_fill.sv
// One full sweep per rising edge of cart_download; the RAM itself lives outside
`timescale 1ns/1ps
`default_nettype none

module wram_clear_fill (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     cart_download,
	input  wire cart_pkg::wram_init_t wram_init,
	output logic                    clearing,
	output host_pkg::fill_addr_t    fill_addr,
	output logic [7:0]              fill_data,
	output logic                    fill_wren
);

	logic download_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d <= 1'b0;
			clearing <= 1'b0;
			fill_addr <= '0;
		end else begin
			download_d <= cart_download;
			if (cart_download && !download_d)
				clearing <= 1'b1;
			else if (&fill_addr)
				clearing <= 1'b0;
			// Wraps back to zero on the last address
			if (clearing)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	assign fill_wren = clearing;

	// Patterns seen on real consoles at power on
	always_comb begin
		case (wram_init)
			cart_pkg::wram_snes2_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::wram_snes1_00ff: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::wram_fill_55:    fill_data = 8'h55;
			default:                   fill_data = 8'hFF;
		endcase
	end

	// No stray writes into work RAM once the core runs
	assert property (@(posedge clk_sys) disable iff (reset) !clearing |-> !fill_wren)
		else $error("fill_wren outside of a clear");

endmodule

`default_nettype wire

//--- snes_cart_ctrl.f
hw/cart_pkg.sv
hw/host_pkg.sv
hw/rom_header_detect.sv
hw/cheat_code_loader.sv
hw/wram_clear_fill.sv
hw/backup_sector_seq.sv
hw/snes_cart_ctrl.sv
testbench/snes_cart_ctrl_tb.sv

//--- testbench/snes_cart_ctrl_stimulus.txt
# Columns: name kind arg0 arg1 arg2 arg3 exp0 exp1 exp2, numbers in hex
# hdr: header_mode word_at_0 rom_size_word ram_size_word -> rom_type rom_mask ram_mask
# region: region_sel word_at_2 unused unused -> pal unused unused
# cheat: flags address compare replace -> record gg_valid_pulses unused
# clear: wram_init addr0 addr1 addr2 -> data0 data1 data2
# load: word_at_0 unused unused unused -> sectors ram_mask unused
# autosave: all args unused -> sectors unused unused
hdr_auto_sized     hdr 0 013A 0    0    01 0FFFFF 001FFF
hdr_auto_default   hdr 0 0500 0    0    05 3FFFFF 000000
hdr_no_header      hdr 1 1234 0    0    00 3FFFFF 000000
hdr_lorom          hdr 2 0000 0900 0001 00 07FFFF 0007FF
hdr_hirom          hdr 3 0000 0A00 0005 01 0FFFFF 007FFF
hdr_exhirom        hdr 4 0000 0D00 0003 02 7FFFFF 001FFF
# Region bit is bit 8 of the word at byte 2
region_force_pal   region 2 0000 0 0 1 0 0
region_force_ntsc  region 1 0100 0 0 0 0 0
region_auto_pal    region 0 0100 0 0 1 0 0
region_auto_ntsc   region 0 0000 0 0 0 0 0
cheat_scrambled    cheat 12345678 007E1234 000000AB 000000CD 12345678007E1234000000AB000000CD 1 0
cheat_second       cheat 00000000 00C0FFEE 00000000 0000005A 0000000000C0FFEE000000000000005A 1 0
# Sample addresses are fill_addr values
clear_snes2_9966   clear 0 00000 00004 00104 99 66 99
clear_snes1_00ff   clear 1 00001 00200 00201 FF FF 00
clear_fill_55      clear 2 00000 12345 1FFFF 55 55 55
clear_fill_ff      clear 3 00010 0ABCD 1FFFF FF FF FF
# RAM size code 2 gives a 4 KB save, eight sectors
load_after_dl      load 0021 0 0 0 8 000FFF 0
autosave_menu      autosave 0 0 0 0 8 0 0

//--- testbench/snes_cart_ctrl_tb.sv
// Needs the stimulus file at testbench/ relative to the run directory; each clear runs 2^17 cycles
`timescale 1ns/1ps
`default_nettype none

module snes_cart_ctrl_tb;

	logic                   clk_sys;
	logic                   reset;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	host_pkg::ioctl_addr_t  ioctl_addr;
	host_pkg::ioctl_word_t  ioctl_dout;
	logic                   ioctl_wr;
	cart_pkg::header_mode_t header_mode;
	cart_pkg::region_sel_t  region_sel;
	cart_pkg::wram_init_t   wram_init;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   img_size_nz;
	logic                   sd_ack;
	logic                   bk_load_req;
	logic                   bk_save_req;
	logic                   autosave_en;
	logic                   osd_status;
	logic                   bsram_write;
	cart_pkg::mapper_t      rom_type;
	cart_pkg::mem_mask_t    rom_mask;
	cart_pkg::mem_mask_t    ram_mask;
	logic                   pal;
	host_pkg::cheat_code_t  gg_code;
	logic                   gg_valid;
	logic                   clearing;
	host_pkg::fill_addr_t   fill_addr;
	logic [7:0]             fill_data;
	logic                   fill_wren;
	host_pkg::sector_t      sd_lba;
	logic                   sd_rd;
	logic                   sd_wr;
	logic                   bk_busy;
	logic                   bk_loading;
	logic                   bk_pending;
	logic                   core_hold;

	// Test bookkeeping
	string             cur_name;
	int                test_errors;
	int                tests_run;
	int                tests_failed;
	int                host_errors;
	int                setup_errors;
	int                valid_seen;
	int                rd_count;
	int                wr_count;
	integer            seed;
	host_pkg::sector_t lba_log[$];
	logic [127:0]      arg[0:3];
	logic [127:0]      want[0:2];

	snes_cart_ctrl dut0 (.*);

	always #50 clk_sys = ~clk_sys;

	// ==========================================================================
	// Host side of the sector handshake with a random latency per sector
	// ==========================================================================
	always begin : host_model
		int delay;
		int n;
		@(negedge clk_sys);
		if ((sd_rd || sd_wr) && !sd_ack) begin
			if (sd_rd)
				rd_count++;
			else
				wr_count++;
			lba_log.push_back(sd_lba);
			delay = 1 + ({$random(seed)} % 8);
			repeat (delay) @(negedge clk_sys);
			sd_ack = 1'b1;
			n = 0;
			while ((sd_rd || sd_wr) && n < 16) begin
				@(negedge clk_sys);
				n++;
			end
			if (sd_rd || sd_wr) begin
				$display("Host model: request strobe stayed high after sd_ack");
				host_errors++;
			end
			sd_ack = 1'b0;
		end
	end

	// ==========================================================================
	// Checks and waits
	// ==========================================================================
	task automatic check_value(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s %s expected %0h actual %0h", cur_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Test %s timed out waiting for %s", cur_name, what);
		test_errors++;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy !== level)
			report_timeout(level ? "bk_busy to rise" : "bk_busy to fall");
	endtask

	task automatic wait_clearing(input logic level, input int limit);
		int n;
		n = 0;
		while (clearing !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (clearing !== level)
			report_timeout(level ? "clearing to rise" : "clearing to fall");
	endtask

	// One download word per strobe
	task automatic begin_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl_index = index;
		ioctl_download = 1'b1;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic write_word(input host_pkg::ioctl_addr_t addr, input host_pkg::ioctl_word_t data);
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (gg_valid)
			valid_seen++;
	endtask

	// ==========================================================================
	// Test kinds
	// ==========================================================================
	task automatic run_header();
		host_pkg::ioctl_addr_t info;
		@(negedge clk_sys);
		header_mode = cart_pkg::header_mode_t'(arg[0][2:0]);
		img_mounted = 1'b0;
		begin_download(8'h00);
		write_word('0, arg[1][15:0]);
		case (header_mode)
			cart_pkg::hdr_lorom:   info = host_pkg::ioctl_addr_t'(cart_pkg::info_lorom);
			cart_pkg::hdr_hirom:   info = host_pkg::ioctl_addr_t'(cart_pkg::info_hirom);
			cart_pkg::hdr_exhirom: info = host_pkg::ioctl_addr_t'(cart_pkg::info_exhirom);
			default:               info = '0;
		endcase
		// Info block sits behind the copier header
		if (info != '0) begin
			info = info + host_pkg::ioctl_addr_t'(cart_pkg::copier_offset);
			write_word(info, arg[2][15:0]);
			write_word(info + host_pkg::ioctl_addr_t'(cart_pkg::ram_size_step), arg[3][15:0]);
		end
		end_download();
		@(negedge clk_sys);
		check_value("rom_type", want[0], rom_type);
		check_value("rom_mask", want[1], rom_mask);
		check_value("ram_mask", want[2], ram_mask);
	endtask

	task automatic run_region();
		@(negedge clk_sys);
		header_mode = cart_pkg::hdr_auto;
		region_sel = cart_pkg::region_sel_t'(arg[0][1:0]);
		begin_download(8'h00);
		write_word(host_pkg::ioctl_addr_t'(2), arg[1][15:0]);
		end_download();
		repeat (2) @(negedge clk_sys);
		check_value("pal", want[0], pal);
	endtask

	task automatic run_cheat();
		int           order[8] = '{6, 0, 12, 2, 10, 4, 8, 14};
		logic [127:0] record;
		logic [31:0]  field;
		int           n;
		record = {arg[0][31:0], arg[1][31:0], arg[2][31:0], arg[3][31:0]};
		valid_seen = 0;
		begin_download(host_pkg::code_index);
		for (n = 0; n < 8; n++) begin
			field = record[127 - 32 * (order[n] / 4) -: 32];
			write_word(host_pkg::ioctl_addr_t'(order[n]),
				((order[n] & 2) != 0) ? field[31:16] : field[15:0]);
		end
		for (n = 0; n < 4; n++) begin
			@(negedge clk_sys);
			if (gg_valid)
				valid_seen++;
		end
		end_download();
		check_value("gg_code", want[0], gg_code);
		check_value("gg_valid pulses", want[1], valid_seen);
	endtask

	task automatic run_clear();
		int cycles;
		int hold_gaps;
		int wren_gaps;
		int seen;
		int n;
		wait_clearing(1'b0, 140000);
		wram_init = cart_pkg::wram_init_t'(arg[0][1:0]);
		img_mounted = 1'b0;
		begin_download(8'h00);
		wait_clearing(1'b1, 8);
		cycles = 0;
		hold_gaps = 0;
		wren_gaps = 0;
		seen = 0;
		while (clearing && cycles < 140000) begin
			cycles++;
			if (!core_hold)
				hold_gaps++;
			if (fill_wren !== 1'b1)
				wren_gaps++;
			for (n = 0; n < 3; n++) begin
				if (fill_addr == arg[n + 1][16:0]) begin
					check_value("fill_data", want[n], fill_data);
					seen++;
				end
			end
			// The sweep outlasts a short download
			if (cycles == 4)
				ioctl_download = 1'b0;
			@(negedge clk_sys);
		end
		if (clearing)
			report_timeout("clearing to end");
		check_value("clear cycles", 1 << host_pkg::fill_addr_bits, cycles);
		check_value("core_hold gaps", 0, hold_gaps);
		check_value("fill_wren gaps", 0, wren_gaps);
		check_value("fill_wren after clear", 0, fill_wren);
		check_value("samples seen", 3, seen);
	endtask

	task automatic run_backup(input logic save);
		int n;
		@(negedge clk_sys);
		lba_log.delete();
		rd_count = 0;
		wr_count = 0;
		if (!save) begin
			header_mode = cart_pkg::hdr_auto;
			img_mounted = 1'b1;
			img_readonly = 1'b0;
			img_size_nz = 1'b1;
			begin_download(8'h00);
			write_word('0, arg[0][15:0]);
			end_download();
		end else begin
			bsram_write = 1'b1;
			@(negedge clk_sys);
			bsram_write = 1'b0;
			check_value("bk_pending set", 1, bk_pending);
			// Menu opens
			autosave_en = 1'b1;
			osd_status = 1'b1;
		end
		wait_busy(1'b1, 10);
		check_value("bk_loading during transfer", !save, bk_loading);
		wait_busy(1'b0, 500);
		check_value(save ? "sd_wr requests" : "sd_rd requests", want[0], save ? wr_count : rd_count);
		check_value(save ? "sd_rd requests" : "sd_wr requests", 0, save ? rd_count : wr_count);
		for (n = 0; n < lba_log.size(); n++)
			check_value("sd_lba", n, lba_log[n]);
		check_value("bk_loading", 0, bk_loading);
		check_value("bk_pending", 0, bk_pending);
		if (!save)
			check_value("ram_mask", want[1], ram_mask);
		osd_status = 1'b0;
		autosave_en = 1'b0;
	endtask

	task automatic run_test(input string name, input string kind);
		cur_name = name;
		test_errors = 0;
		if (kind == "hdr")
			run_header();
		else if (kind == "region")
			run_region();
		else if (kind == "cheat")
			run_cheat();
		else if (kind == "clear")
			run_clear();
		else if (kind == "load")
			run_backup(1'b0);
		else if (kind == "autosave")
			run_backup(1'b1);
		else begin
			$display("Test %s has an unknown kind %s", name, kind);
			test_errors++;
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %s ok", name);
		end else begin
			$display("Test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
	endtask

	// ==========================================================================
	// Main sequence
	// ==========================================================================
	initial begin
		int    fd;
		int    code;
		int    c;
		logic  done;
		string name;
		string kind;
		clk_sys = 1'b0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		header_mode = cart_pkg::hdr_auto;
		region_sel = cart_pkg::region_auto;
		wram_init = cart_pkg::wram_snes2_9966;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		sd_ack = 1'b0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		autosave_en = 1'b0;
		osd_status = 1'b0;
		bsram_write = 1'b0;
		seed = 17171;
		tests_run = 0;
		tests_failed = 0;
		host_errors = 0;
		setup_errors = 0;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;

		fd = $fopen("testbench/snes_cart_ctrl_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			setup_errors++;
		end
		done = (fd == 0);
		while (!done) begin
			code = $fscanf(fd, "%s", name);
			if (code != 1) begin
				done = 1'b1;
			end else if (name[0] == "#") begin
				// Skip the rest of a comment line
				c = 0;
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end else begin
				code = $fscanf(fd, "%s %h %h %h %h %h %h %h", kind, arg[0], arg[1], arg[2],
					arg[3], want[0], want[1], want[2]);
				if (code != 8) begin
					$display("Stimulus line for %s is incomplete", name);
					setup_errors++;
					done = 1'b1;
				end else begin
					run_test(name, kind);
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests run %0d, passed %0d, failed %0d, host errors %0d", tests_run,
			tests_run - tests_failed, tests_failed, host_errors + setup_errors);
		if (tests_run > 0 && tests_failed == 0 && host_errors == 0 && setup_errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire
